/* design/cache_geom_pkg.sv */
/*
 * cache geometry
 * sizes of the two-bank block cache and the load/store request
 */
package cache_geom_pkg;

  localparam int addr_width = 12;
  localparam int data_width = 32;
  localparam int block_words = 4;
  localparam int sets = 4;
  localparam int ways = 2;

  // fields of a byte address
  localparam int byte_off_bits = $clog2(data_width / 8);
  localparam int block_off_bits = byte_off_bits + $clog2(block_words);
  localparam int word_bits = block_off_bits - byte_off_bits;
  localparam int set_bits = $clog2(sets);
  localparam int way_bits = $clog2(ways);

  // one bank holds every way of every set
  localparam int mem_els = ways * sets * block_words;
  localparam int mem_addr_bits = $clog2(mem_els);

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [way_bits-1:0]   way;
    logic [set_bits-1:0]   set;
    logic [word_bits-1:0]  word;
    logic [data_width-1:0] data;
  } cpu_req_s;

endpackage

/* design/dma_if_pkg.sv */
/*
 * DMA interface
 * commands from the miss controller and packets to the backing memory
 */
package dma_if_pkg;

  typedef enum logic [2:0] {
    e_dma_nop,
    e_dma_send_fill_addr,
    e_dma_send_evict_addr,
    e_dma_get_fill_data,
    e_dma_send_evict_data
  } dma_cmd_e;

  // addr is always block aligned
  typedef struct packed {
    logic                                  write_not_read;
    logic [cache_geom_pkg::addr_width-1:0] addr;
  } dma_pkt_s;

endpackage

/* design/dma_fifo.sv */
/*
 * small FIFO
 * circular buffer of els_p entries of any payload type
 * valid/ready on the input side, valid/yumi on the output side
 */
`timescale 1ns/1ps

module dma_fifo #(
  parameter int els_p = 2,
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     v_o,
  output payload_t data_o,
  input  logic     yumi_i
);

  localparam int ptr_w = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w = $clog2(els_p + 1);

  payload_t mem_r [els_p];
  logic [ptr_w-1:0] wptr_r;
  logic [ptr_w-1:0] rptr_r;
  logic [cnt_w-1:0] count_r;
  logic push;

  assign ready_o = (count_r != cnt_w'(els_p));
  assign v_o = (count_r != '0);
  assign data_o = mem_r[rptr_r];
  assign push = v_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r <= '0;
      rptr_r <= '0;
      count_r <= '0;
    end else begin
      if (push) begin
        wptr_r <= (wptr_r == ptr_w'(els_p - 1)) ? '0 : wptr_r + 1'b1;
      end
      // yumi is only given while v_o is high
      if (yumi_i) begin
        rptr_r <= (rptr_r == ptr_w'(els_p - 1)) ? '0 : rptr_r + 1'b1;
      end
      count_r <= count_r + cnt_w'(push) - cnt_w'(yumi_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wptr_r] <= data_i;
    end
  end

endmodule

/* design/block_mem.sv */
/*
 * bank data array
 * one word per way, set and word offset, with a load/store port for the
 * pipeline and a DMA port for block moves, both read in one cycle
 */
`timescale 1ns/1ps

module block_mem (
  input  logic                                     clk_i,
  input  cache_geom_pkg::cpu_req_s                 cpu_req_i,
  output logic [cache_geom_pkg::data_width-1:0]    cpu_rdata_o,
  input  logic                                     dma_v_i,
  input  logic                                     dma_w_i,
  input  logic [cache_geom_pkg::mem_addr_bits-1:0] dma_addr_i,
  input  logic [cache_geom_pkg::data_width-1:0]    dma_wdata_i,
  output logic [cache_geom_pkg::data_width-1:0]    dma_rdata_o
);

  logic [cache_geom_pkg::data_width-1:0] mem_r [cache_geom_pkg::mem_els];
  logic [cache_geom_pkg::mem_addr_bits-1:0] cpu_idx;

  assign cpu_idx = {cpu_req_i.way, cpu_req_i.set, cpu_req_i.word};

  always_ff @(posedge clk_i) begin
    if (cpu_req_i.valid) begin
      if (cpu_req_i.write) begin
        mem_r[cpu_idx] <= cpu_req_i.data;
      end else begin
        cpu_rdata_o <= mem_r[cpu_idx];
      end
    end
    // dma write comes last so it wins on the same entry
    if (dma_v_i) begin
      if (dma_w_i) begin
        mem_r[dma_addr_i] <= dma_wdata_i;
      end else begin
        dma_rdata_o <= mem_r[dma_addr_i];
      end
    end
  end

endmodule

/* design/cache_dma.sv */
/*
 * cache DMA engine
 * sends fill and evict packets, writes returned fill words into one way of
 * the bank and streams an evicted block out word by word
 */
`timescale 1ns/1ps

module cache_dma (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  dma_if_pkg::dma_cmd_e                     dma_cmd_i,
  input  logic [cache_geom_pkg::way_bits-1:0]      dma_way_i,
  input  logic [cache_geom_pkg::addr_width-1:0]    dma_addr_i,
  output logic                                     done_o,
  output logic [cache_geom_pkg::data_width-1:0]    snoop_word_o,
  output dma_if_pkg::dma_pkt_s                     dma_pkt_o,
  output logic                                     dma_pkt_v_o,
  input  logic                                     dma_pkt_yumi_i,
  input  logic [cache_geom_pkg::data_width-1:0]    dma_data_i,
  input  logic                                     dma_data_v_i,
  output logic                                     dma_data_ready_o,
  output logic [cache_geom_pkg::data_width-1:0]    evict_data_o,
  output logic                                     evict_v_o,
  input  logic                                     evict_yumi_i,
  output logic                                     mem_v_o,
  output logic                                     mem_w_o,
  output logic [cache_geom_pkg::mem_addr_bits-1:0] mem_addr_o,
  output logic [cache_geom_pkg::data_width-1:0]    mem_wdata_o,
  input  logic [cache_geom_pkg::data_width-1:0]    mem_rdata_i
);

  localparam int cnt_w = $clog2(cache_geom_pkg::block_words + 1);
  localparam int wb = cache_geom_pkg::word_bits;
  localparam int bob = cache_geom_pkg::block_off_bits;

  typedef enum logic [1:0] {IDLE, GET_FILL_DATA, SEND_EVICT_DATA} state_e;

  state_e state_r;
  state_e state_n;
  logic [cnt_w-1:0] cnt_r;
  logic cnt_clear;
  logic cnt_up;
  logic fill_max;
  logic evict_max;
  logic in_v;
  logic in_yumi;
  logic [cache_geom_pkg::data_width-1:0] in_data;
  logic out_v;
  logic out_ready;
  logic snoop_we;

  dma_fifo #(
    .els_p(4),
    .payload_t(logic [cache_geom_pkg::data_width-1:0])
  ) in_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(dma_data_v_i),
    .data_i(dma_data_i),
    .ready_o(dma_data_ready_o),
    .v_o(in_v),
    .data_o(in_data),
    .yumi_i(in_yumi)
  );

  // holds words read from the bank until the memory takes them
  dma_fifo #(
    .els_p(2),
    .payload_t(logic [cache_geom_pkg::data_width-1:0])
  ) out_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(out_v),
    .data_i(mem_rdata_i),
    .ready_o(out_ready),
    .v_o(evict_v_o),
    .data_o(evict_data_o),
    .yumi_i(evict_yumi_i)
  );

  assign fill_max = (cnt_r == cnt_w'(cache_geom_pkg::block_words - 1));
  assign evict_max = (cnt_r == cnt_w'(cache_geom_pkg::block_words));

  assign mem_addr_o = {dma_way_i, dma_addr_i[bob +: cache_geom_pkg::set_bits], cnt_r[wb-1:0]};
  assign mem_wdata_o = in_data;

  always_comb begin
    state_n = state_r;
    done_o = 1'b0;
    dma_pkt_v_o = 1'b0;
    dma_pkt_o.write_not_read = 1'b0;
    dma_pkt_o.addr = {dma_addr_i[cache_geom_pkg::addr_width-1:bob], {bob{1'b0}}};
    mem_v_o = 1'b0;
    mem_w_o = 1'b0;
    in_yumi = 1'b0;
    out_v = 1'b0;
    cnt_clear = 1'b0;
    cnt_up = 1'b0;
    unique case (state_r)
      IDLE: begin
        case (dma_cmd_i)
          dma_if_pkg::e_dma_send_fill_addr: begin
            dma_pkt_v_o = 1'b1;
            done_o = dma_pkt_yumi_i;
          end
          dma_if_pkg::e_dma_send_evict_addr: begin
            dma_pkt_v_o = 1'b1;
            dma_pkt_o.write_not_read = 1'b1;
            done_o = dma_pkt_yumi_i;
          end
          dma_if_pkg::e_dma_get_fill_data: begin
            cnt_clear = 1'b1;
            state_n = GET_FILL_DATA;
          end
          dma_if_pkg::e_dma_send_evict_data: begin
            // word 0 is read on the way out, so the count starts at 1
            mem_v_o = 1'b1;
            cnt_clear = 1'b1;
            cnt_up = 1'b1;
            state_n = SEND_EVICT_DATA;
          end
          default: begin
          end
        endcase
      end
      GET_FILL_DATA: begin
        mem_v_o = in_v;
        mem_w_o = in_v;
        in_yumi = in_v;
        if (in_v) begin
          if (fill_max) begin
            done_o = 1'b1;
            cnt_clear = 1'b1;
            state_n = IDLE;
          end else begin
            cnt_up = 1'b1;
          end
        end
      end
      SEND_EVICT_DATA: begin
        // the bank output holds the word read one cycle earlier
        out_v = 1'b1;
        if (out_ready) begin
          if (evict_max) begin
            done_o = 1'b1;
            cnt_clear = 1'b1;
            state_n = IDLE;
          end else begin
            mem_v_o = 1'b1;
            cnt_up = 1'b1;
          end
        end
      end
      default: begin
        state_n = IDLE;
      end
    endcase
  end

  assign snoop_we = (state_r == GET_FILL_DATA) & in_v
                  & (cnt_r[wb-1:0] == dma_addr_i[cache_geom_pkg::byte_off_bits +: wb]);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      cnt_r <= '0;
    end else begin
      state_r <= state_n;
      if (cnt_clear) begin
        cnt_r <= cnt_w'(cnt_up);
      end else if (cnt_up) begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (snoop_we) begin
      snoop_word_o <= in_data;
    end
  end

endmodule

/* design/dma_arbiter.sv */
/*
 * DMA arbiter
 * round-robin grant of engine packets to the backing memory, locked to the
 * winner until its whole block of fill or evict words has moved
 */
`timescale 1ns/1ps

module dma_arbiter #(
  parameter int num_banks_p = 2
) (
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,
  input  logic [num_banks_p-1:0]                                  pkt_v_i,
  input  dma_if_pkg::dma_pkt_s [num_banks_p-1:0]                  pkt_i,
  output logic [num_banks_p-1:0]                                  pkt_yumi_o,
  output logic [num_banks_p-1:0]                                  fill_v_o,
  output logic [cache_geom_pkg::data_width-1:0]                   fill_data_o,
  input  logic [num_banks_p-1:0]                                  fill_ready_i,
  input  logic [num_banks_p-1:0]                                  evict_v_i,
  input  logic [num_banks_p-1:0][cache_geom_pkg::data_width-1:0]  evict_data_i,
  output logic [num_banks_p-1:0]                                  evict_yumi_o,
  output dma_if_pkg::dma_pkt_s                                    mem_pkt_o,
  output logic                                                    mem_pkt_v_o,
  input  logic                                                    mem_pkt_yumi_i,
  input  logic [cache_geom_pkg::data_width-1:0]                   mem_rdata_i,
  input  logic                                                    mem_rdata_v_i,
  output logic                                                    mem_rdata_ready_o,
  output logic [cache_geom_pkg::data_width-1:0]                   mem_wdata_o,
  output logic                                                    mem_wdata_v_o,
  input  logic                                                    mem_wdata_yumi_i
);

  localparam int sel_w = (num_banks_p > 1) ? $clog2(num_banks_p) : 1;
  localparam int beat_w = (cache_geom_pkg::block_words > 1) ?
                          $clog2(cache_geom_pkg::block_words) : 1;

  logic lock_r;
  logic write_r;
  logic [sel_w-1:0] owner_r;
  logic [sel_w-1:0] prio_r;
  logic [sel_w-1:0] pick;
  logic [beat_w-1:0] beat_r;
  logic found;
  logic beat;
  logic [num_banks_p-1:0] grant;
  int unsigned rr_idx;

  // first valid requester at or after the priority pointer
  always_comb begin
    pick = prio_r;
    found = 1'b0;
    rr_idx = 0;
    for (int i = 0; i < num_banks_p; i++) begin
      rr_idx = (int'(prio_r) + i) % num_banks_p;
      if (!found && pkt_v_i[rr_idx]) begin
        found = 1'b1;
        pick = sel_w'(rr_idx);
      end
    end
    grant = '0;
    if (lock_r) begin
      grant[owner_r] = 1'b1;
    end else if (found) begin
      grant[pick] = 1'b1;
    end
  end

  assign mem_pkt_o = pkt_i[pick];
  assign mem_pkt_v_o = ~lock_r & found;
  assign pkt_yumi_o = grant & {num_banks_p{~lock_r & mem_pkt_yumi_i}};

  // fill data is shared, only the owner sees it valid
  assign fill_data_o = mem_rdata_i;
  assign fill_v_o = grant & {num_banks_p{lock_r & ~write_r & mem_rdata_v_i}};
  assign mem_rdata_ready_o = lock_r & ~write_r & fill_ready_i[owner_r];

  assign mem_wdata_o = evict_data_i[owner_r];
  assign mem_wdata_v_o = lock_r & write_r & evict_v_i[owner_r];
  assign evict_yumi_o = grant & {num_banks_p{lock_r & write_r & mem_wdata_yumi_i}};

  assign beat = (mem_wdata_v_o & mem_wdata_yumi_i) | (mem_rdata_v_i & mem_rdata_ready_o);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_r <= 1'b0;
      write_r <= 1'b0;
      owner_r <= '0;
      prio_r <= '0;
      beat_r <= '0;
    end else if (!lock_r) begin
      if (mem_pkt_v_o && mem_pkt_yumi_i) begin
        lock_r <= 1'b1;
        owner_r <= pick;
        write_r <= pkt_i[pick].write_not_read;
        prio_r <= (pick == sel_w'(num_banks_p - 1)) ? '0 : pick + 1'b1;
        beat_r <= '0;
      end
    end else if (beat) begin
      beat_r <= beat_r + 1'b1;
      if (beat_r == beat_w'(cache_geom_pkg::block_words - 1)) begin
        lock_r <= 1'b0;
      end
    end
  end

endmodule

/* design/backing_mem.sv */
/*
 * backing memory
 * queues DMA packets, returns a block one word per cycle for a fill and
 * absorbs one evict word per cycle for a write
 */
`timescale 1ns/1ps

module backing_mem #(
  parameter int words_p = 256
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  dma_if_pkg::dma_pkt_s                  pkt_i,
  input  logic                                  pkt_v_i,
  output logic                                  pkt_yumi_o,
  output logic [cache_geom_pkg::data_width-1:0] rdata_o,
  output logic                                  rdata_v_o,
  input  logic                                  rdata_ready_i,
  input  logic [cache_geom_pkg::data_width-1:0] wdata_i,
  input  logic                                  wdata_v_i,
  output logic                                  wdata_yumi_o
);

  localparam int idx_w = $clog2(words_p);
  localparam int beat_w = cache_geom_pkg::word_bits;

  logic [cache_geom_pkg::data_width-1:0] mem_r [words_p];
  dma_if_pkg::dma_pkt_s head;
  logic head_v;
  logic head_seen_r;
  logic fifo_ready;
  logic beat;
  logic last_beat;
  logic [beat_w-1:0] beat_r;
  logic [idx_w-1:0] word_idx;

  dma_fifo #(
    .els_p(2),
    .payload_t(dma_if_pkg::dma_pkt_s)
  ) pkt_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(pkt_v_i),
    .data_i(pkt_i),
    .ready_o(fifo_ready),
    .v_o(head_v),
    .data_o(head),
    .yumi_i(last_beat)
  );

  assign pkt_yumi_o = pkt_v_i & fifo_ready;
  assign word_idx = head.addr[cache_geom_pkg::byte_off_bits +: idx_w] + idx_w'(beat_r);

  // a new head waits one cycle before its first read word
  assign rdata_o = mem_r[word_idx];
  assign rdata_v_o = head_v & ~head.write_not_read & head_seen_r;
  assign wdata_yumi_o = head_v & head.write_not_read & wdata_v_i;

  assign beat = (rdata_v_o & rdata_ready_i) | wdata_yumi_o;
  assign last_beat = beat & (beat_r == beat_w'(cache_geom_pkg::block_words - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      beat_r <= '0;
      head_seen_r <= 1'b0;
    end else begin
      head_seen_r <= head_v & ~last_beat;
      if (beat) begin
        beat_r <= beat_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wdata_yumi_o) begin
      mem_r[word_idx] <= wdata_i;
    end
  end

endmodule

/* design/dma_subsystem.sv */
/*
 * two-bank cache DMA subsystem
 * each bank has a data array and a DMA engine, both engines reach one
 * backing memory through the arbiter
 */
`timescale 1ns/1ps

module dma_subsystem #(
  parameter int num_banks_p = 2,
  parameter int words_p = 256
) (
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,
  input  dma_if_pkg::dma_cmd_e [num_banks_p-1:0]                  dma_cmd_i,
  input  logic [num_banks_p-1:0][cache_geom_pkg::way_bits-1:0]    dma_way_i,
  input  logic [num_banks_p-1:0][cache_geom_pkg::addr_width-1:0]  dma_addr_i,
  output logic [num_banks_p-1:0]                                  dma_done_o,
  output logic [num_banks_p-1:0][cache_geom_pkg::data_width-1:0]  snoop_word_o,
  input  cache_geom_pkg::cpu_req_s [num_banks_p-1:0]              cpu_req_i,
  output logic [num_banks_p-1:0][cache_geom_pkg::data_width-1:0]  cpu_rdata_o
);

  localparam int dw = cache_geom_pkg::data_width;

  dma_if_pkg::dma_pkt_s [num_banks_p-1:0] pkt;
  logic [num_banks_p-1:0] pkt_v;
  logic [num_banks_p-1:0] pkt_yumi;
  logic [num_banks_p-1:0] fill_v;
  logic [num_banks_p-1:0] fill_ready;
  logic [num_banks_p-1:0] evict_v;
  logic [num_banks_p-1:0] evict_yumi;
  logic [num_banks_p-1:0][dw-1:0] evict_data;
  logic [dw-1:0] fill_data;
  logic [num_banks_p-1:0] mem_v;
  logic [num_banks_p-1:0] mem_w;
  logic [num_banks_p-1:0][cache_geom_pkg::mem_addr_bits-1:0] mem_addr;
  logic [num_banks_p-1:0][dw-1:0] mem_wdata;
  logic [num_banks_p-1:0][dw-1:0] mem_rdata;

  dma_if_pkg::dma_pkt_s bm_pkt;
  logic bm_pkt_v;
  logic bm_pkt_yumi;
  logic [dw-1:0] bm_rdata;
  logic bm_rdata_v;
  logic bm_rdata_ready;
  logic [dw-1:0] bm_wdata;
  logic bm_wdata_v;
  logic bm_wdata_yumi;

  for (genvar b = 0; b < num_banks_p; b++) begin : g_bank
    block_mem i_block_mem (
      .clk_i(clk_i),
      .cpu_req_i(cpu_req_i[b]),
      .cpu_rdata_o(cpu_rdata_o[b]),
      .dma_v_i(mem_v[b]),
      .dma_w_i(mem_w[b]),
      .dma_addr_i(mem_addr[b]),
      .dma_wdata_i(mem_wdata[b]),
      .dma_rdata_o(mem_rdata[b])
    );

    cache_dma i_cache_dma (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .dma_cmd_i(dma_cmd_i[b]),
      .dma_way_i(dma_way_i[b]),
      .dma_addr_i(dma_addr_i[b]),
      .done_o(dma_done_o[b]),
      .snoop_word_o(snoop_word_o[b]),
      .dma_pkt_o(pkt[b]),
      .dma_pkt_v_o(pkt_v[b]),
      .dma_pkt_yumi_i(pkt_yumi[b]),
      .dma_data_i(fill_data),
      .dma_data_v_i(fill_v[b]),
      .dma_data_ready_o(fill_ready[b]),
      .evict_data_o(evict_data[b]),
      .evict_v_o(evict_v[b]),
      .evict_yumi_i(evict_yumi[b]),
      .mem_v_o(mem_v[b]),
      .mem_w_o(mem_w[b]),
      .mem_addr_o(mem_addr[b]),
      .mem_wdata_o(mem_wdata[b]),
      .mem_rdata_i(mem_rdata[b])
    );
  end

  dma_arbiter #(
    .num_banks_p(num_banks_p)
  ) i_dma_arbiter (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .pkt_v_i(pkt_v),
    .pkt_i(pkt),
    .pkt_yumi_o(pkt_yumi),
    .fill_v_o(fill_v),
    .fill_data_o(fill_data),
    .fill_ready_i(fill_ready),
    .evict_v_i(evict_v),
    .evict_data_i(evict_data),
    .evict_yumi_o(evict_yumi),
    .mem_pkt_o(bm_pkt),
    .mem_pkt_v_o(bm_pkt_v),
    .mem_pkt_yumi_i(bm_pkt_yumi),
    .mem_rdata_i(bm_rdata),
    .mem_rdata_v_i(bm_rdata_v),
    .mem_rdata_ready_o(bm_rdata_ready),
    .mem_wdata_o(bm_wdata),
    .mem_wdata_v_o(bm_wdata_v),
    .mem_wdata_yumi_i(bm_wdata_yumi)
  );

  backing_mem #(
    .words_p(words_p)
  ) i_backing_mem (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .pkt_i(bm_pkt),
    .pkt_v_i(bm_pkt_v),
    .pkt_yumi_o(bm_pkt_yumi),
    .rdata_o(bm_rdata),
    .rdata_v_o(bm_rdata_v),
    .rdata_ready_i(bm_rdata_ready),
    .wdata_i(bm_wdata),
    .wdata_v_i(bm_wdata_v),
    .wdata_yumi_o(bm_wdata_yumi)
  );

endmodule

/* test/dma_subsystem_assertions.sv */
/*
 * handshake assertions
 * bound into each DMA engine and into the arbiter
 */
`timescale 1ns/1ps

module dma_subsystem_assertions (
  input logic                 clk_i,
  input logic                 reset_i,
  input logic                 pkt_v_i,
  input logic                 pkt_yumi_i,
  input dma_if_pkg::dma_pkt_s pkt_i,
  input logic                 done_i,
  input logic                 idle_i,
  input dma_if_pkg::dma_cmd_e cmd_i,
  input logic [1:0]           grant_i
);

  // a packet stays offered and unchanged until it is taken
  a_pkt_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    pkt_v_i && !pkt_yumi_i |=> pkt_v_i && $stable(pkt_i))
    else $error("packet valid dropped or packet changed before yumi");

  a_idle_done: assert property (@(posedge clk_i) disable iff (reset_i)
    idle_i && cmd_i == dma_if_pkg::e_dma_nop |-> !done_i)
    else $error("done raised in idle with no command");

  a_one_grant: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(grant_i))
    else $error("both requesters granted together");

endmodule

bind cache_dma dma_subsystem_assertions i_engine_checks (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .pkt_v_i(dma_pkt_v_o),
  .pkt_yumi_i(dma_pkt_yumi_i),
  .pkt_i(dma_pkt_o),
  .done_i(done_o),
  .idle_i(state_r == IDLE),
  .cmd_i(dma_cmd_i),
  .grant_i(2'b00)
);

// the shared side toward the backing memory
bind dma_arbiter dma_subsystem_assertions i_bus_checks (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .pkt_v_i(mem_pkt_v_o),
  .pkt_yumi_i(mem_pkt_yumi_i),
  .pkt_i(mem_pkt_o),
  .done_i(1'b0),
  .idle_i(1'b1),
  .cmd_i(dma_if_pkg::e_dma_nop),
  .grant_i(pkt_yumi_o | fill_v_o | evict_yumi_o)
);

/* test/dma_subsystem_tb.sv */
/*
 * testbench for the two-bank cache DMA subsystem
 * plays the load/store pipeline and the miss controller, and keeps a
 * shadow copy of both banks and of the backing memory
 */
`timescale 1ns/1ps

module dma_subsystem_tb;

  localparam int dw = cache_geom_pkg::data_width;
  localparam int aw = cache_geom_pkg::addr_width;
  localparam int wyb = cache_geom_pkg::way_bits;
  localparam int sb = cache_geom_pkg::set_bits;
  localparam int wdb = cache_geom_pkg::word_bits;
  localparam int bw = cache_geom_pkg::block_words;
  localparam int row_cycles = 60;

  typedef enum logic [1:0] {op_store, op_load, op_fill, op_evict} op_e;

  // par marks a DMA row that starts in the same cycle as the row after it
  typedef struct packed {
    op_e            op;
    logic           par;
    logic           bank;
    logic [wyb-1:0] way;
    logic [sb-1:0]  set;
    logic [wdb-1:0] word;
    logic [aw-1:0]  addr;
  } op_s;

  logic clk = 1'b0;
  logic reset;
  dma_if_pkg::dma_cmd_e [1:0] dma_cmd;
  logic [1:0][wyb-1:0] dma_way;
  logic [1:0][aw-1:0] dma_addr;
  logic [1:0] dma_done;
  logic [1:0][dw-1:0] snoop_word;
  cache_geom_pkg::cpu_req_s [1:0] cpu_req;
  logic [1:0][dw-1:0] cpu_rdata;

  logic [dw-1:0] bank_model [2][cache_geom_pkg::mem_els];
  logic [dw-1:0] backing_model [256];
  logic [15:0] lfsr_q;
  op_s ops [$];
  op_s row;
  op_s pair;
  int limit_ns;
  int i;

  dma_subsystem #(
    .num_banks_p(2),
    .words_p(256)
  ) i_dma_subsystem (
    .clk_i(clk),
    .reset_i(reset),
    .dma_cmd_i(dma_cmd),
    .dma_way_i(dma_way),
    .dma_addr_i(dma_addr),
    .dma_done_o(dma_done),
    .snoop_word_o(snoop_word),
    .cpu_req_i(cpu_req),
    .cpu_rdata_o(cpu_rdata)
  );

  always #5 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [dw-1:0] rand_word();
    logic [dw-1:0] w;
    w = '0;
    for (int k = 0; k < dw; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w = {w[dw-2:0], lfsr_q[0]};
    end
    return w;
  endfunction

  function automatic int bank_idx(input int way, input int set, input int word);
    return (way * cache_geom_pkg::sets + set) * bw + word;
  endfunction

  function automatic void add_access(input op_e op, input int bank, input int way,
                                     input int set, input int word);
    op_s r;
    r = '0;
    r.op = op;
    r.bank = bank[0];
    r.way = wyb'(way);
    r.set = sb'(set);
    r.word = wdb'(word);
    ops.push_back(r);
  endfunction

  // set comes from the block address, word is the snoop offset
  function automatic void add_dma(input op_e op, input logic par, input int bank,
                                  input int way, input int addr, input int word);
    op_s r;
    r = '0;
    r.op = op;
    r.par = par;
    r.bank = bank[0];
    r.way = wyb'(way);
    r.addr = aw'(addr);
    r.set = r.addr[cache_geom_pkg::block_off_bits +: sb];
    r.word = wdb'(word);
    ops.push_back(r);
  endfunction

  function automatic void build_table();
    for (int pass = 0; pass < 2; pass++) begin
      for (int b = 0; b < 2; b++) begin
        for (int n = 0; n < cache_geom_pkg::mem_els; n++) begin
          add_access((pass == 0) ? op_store : op_load, b, n / (cache_geom_pkg::sets * bw),
                     (n / bw) % cache_geom_pkg::sets, n % bw);
        end
      end
    end
    // evict from bank 0, refill into the other way of bank 1
    add_dma(op_evict, 1'b0, 0, 0, 'h100, 0);
    add_dma(op_fill, 1'b0, 1, 1, 'h100, 2);
    for (int w = 0; w < bw; w++) begin
      add_access(op_load, 1, 0, 0, w);
    end
    add_dma(op_evict, 1'b0, 1, 0, 'h230, 0);
    // both engines start together
    add_dma(op_evict, 1'b1, 0, 1, 'h390, 0);
    add_dma(op_evict, 1'b0, 1, 1, 'h0a0, 0);
    add_dma(op_evict, 1'b1, 0, 0, 'h1e0, 0);
    add_dma(op_fill, 1'b0, 1, 1, 'h230, 1);
    add_dma(op_fill, 1'b0, 0, 0, 'h0a0, 1);
    add_dma(op_fill, 1'b1, 0, 1, 'h1e0, 3);
    add_dma(op_fill, 1'b0, 1, 0, 'h390, 2);
  endfunction

  task automatic check_value(input string name, input logic [dw-1:0] actual,
                             input logic [dw-1:0] expected);
    if (actual !== expected) begin
      $display("ERR %0t ns %s got %h expected %h", $time, name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic do_store(input int b, input int way, input int set, input int word);
    cpu_req[b].valid = 1'b1;
    cpu_req[b].write = 1'b1;
    cpu_req[b].way = wyb'(way);
    cpu_req[b].set = sb'(set);
    cpu_req[b].word = wdb'(word);
    cpu_req[b].data = rand_word();
    bank_model[b][bank_idx(way, set, word)] = cpu_req[b].data;
    @(negedge clk);
    cpu_req[b].valid = 1'b0;
  endtask

  task automatic do_load(input int b, input int way, input int set, input int word);
    cpu_req[b].valid = 1'b1;
    cpu_req[b].write = 1'b0;
    cpu_req[b].way = wyb'(way);
    cpu_req[b].set = sb'(set);
    cpu_req[b].word = wdb'(word);
    @(negedge clk);
    cpu_req[b].valid = 1'b0;
    check_value($sformatf("cpu_rdata_o[%0d]", b), cpu_rdata[b],
                bank_model[b][bank_idx(way, set, word)]);
  endtask

  // hold the command until done is seen at a rising edge
  task automatic run_command(input int b, input dma_if_pkg::dma_cmd_e cmd);
    dma_cmd[b] = cmd;
    @(posedge clk);
    while (dma_done[b] !== 1'b1) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic dma_transfer(input op_s r);
    int b;
    b = int'(r.bank);
    dma_way[b] = r.way;
    dma_addr[b] = r.addr | (aw'(r.word) << cache_geom_pkg::byte_off_bits);
    if (r.op == op_fill) begin
      run_command(b, dma_if_pkg::e_dma_send_fill_addr);
      run_command(b, dma_if_pkg::e_dma_get_fill_data);
    end else begin
      run_command(b, dma_if_pkg::e_dma_send_evict_addr);
      run_command(b, dma_if_pkg::e_dma_send_evict_data);
    end
    dma_cmd[b] = dma_if_pkg::e_dma_nop;
  endtask

  // update the shadow copy, then check snoop and the filled block
  task automatic finish_dma(input op_s r);
    int b;
    int blk;
    int base;
    b = int'(r.bank);
    blk = int'(r.addr) >> cache_geom_pkg::byte_off_bits;
    base = bank_idx(r.way, r.set, 0);
    for (int w = 0; w < bw; w++) begin
      if (r.op == op_evict) begin
        backing_model[blk + w] = bank_model[b][base + w];
      end else begin
        bank_model[b][base + w] = backing_model[blk + w];
      end
    end
    if (r.op == op_fill) begin
      check_value($sformatf("snoop_word_o[%0d]", b), snoop_word[b],
                  backing_model[blk + int'(r.word)]);
      for (int w = 0; w < bw; w++) begin
        do_load(b, r.way, r.set, w);
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    for (int b = 0; b < 2; b++) begin
      dma_cmd[b] = dma_if_pkg::e_dma_nop;
    end
    dma_way = '0;
    dma_addr = '0;
    cpu_req = '0;
    lfsr_q = 16'd3306;
    build_table();
    limit_ns = (ops.size() + 4) * row_cycles * 10;
    fork
      begin
        #(limit_ns);
        $display("timeout: DMA operation never completed");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
      end
    join_none
    repeat (2) @(negedge clk);
    reset = 1'b0;
    i = 0;
    while (i < ops.size()) begin
      row = ops[i];
      if (row.par) begin
        pair = ops[i + 1];
        fork
          dma_transfer(row);
          dma_transfer(pair);
        join
        finish_dma(row);
        finish_dma(pair);
        i = i + 2;
      end else begin
        case (row.op)
          op_store: do_store(row.bank, row.way, row.set, row.word);
          op_load: do_load(row.bank, row.way, row.set, row.word);
          default: begin
            dma_transfer(row);
            finish_dma(row);
          end
        endcase
        i = i + 1;
      end
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* vlog.f */
design/cache_geom_pkg.sv
design/dma_if_pkg.sv
design/dma_fifo.sv
design/block_mem.sv
design/cache_dma.sv
design/dma_arbiter.sv
design/backing_mem.sv
design/dma_subsystem.sv
test/dma_subsystem_assertions.sv
test/dma_subsystem_tb.sv

/* Makefile */
SIM      := verilator
TOP      := dma_subsystem_tb
FILELIST := vlog.f
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
